/* rv_core_top.f */
+incdir+tb
design/rv_pkg.sv
design/bypass_ifc.sv
design/reg_file.sv
design/forward_unit.sv
design/fetch_unit.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/rv_core_top.sv
tb/tb_rv_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the core and its testbench with Verilator, run it, look for the pass line
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module tb_rv_core -f rv_core_top.f

sim_out=$(./obj_dir/Vtb_rv_core || true)
echo "$sim_out"

if grep -qx "Verification passed" <<< "$sim_out"; then
	exit 0
fi
exit 1

/* tb/ref_model.svh */
// program and reference assume a 256-word ROM and a 64-word RAM; the reference stops at jal x0,0
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

//----------------------------------------------------------------------
// instruction encoders
//----------------------------------------------------------------------
function automatic word_t rtype_word(input int f7, input int rs2, input int rs1,
	input int f3, input int rd);
	return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), op_rtype};
endfunction

function automatic word_t itype_word(input logic [6:0] op, input int imm, input int rs1,
	input int f3, input int rd);
	return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), op};
endfunction

function automatic word_t store_word(input int imm, input int rs2, input int rs1);
	logic [11:0] v;
	v = 12'(imm);
	return {v[11:5], 5'(rs2), 5'(rs1), 3'b010, v[4:0], op_store};
endfunction

function automatic word_t branch_word(input int off, input int rs2, input int rs1, input int f3);
	logic [12:0] v;
	v = 13'(off);
	return {v[12], v[10:5], 5'(rs2), 5'(rs1), 3'(f3), v[4:1], v[11], op_branch};
endfunction

function automatic word_t jal_word(input int off, input int rd);
	logic [20:0] v;
	v = 21'(off);
	return {v[20], v[10:1], v[11], v[19:12], 5'(rd), op_jal};
endfunction

task automatic emit(input word_t w);
	rom[8'(prog_len)] = w;
	prog_len++;
endtask

//----------------------------------------------------------------------
// test program
//----------------------------------------------------------------------
task automatic build_program();
	prog_len = 0;
	emit(itype_word(op_itype, 5, 0, 0, 1));
	emit(itype_word(op_itype, -3, 0, 0, 2));
	// first store, x1 comes from writeback
	emit(store_word(0, 1, 0));
	emit(rtype_word(0, 2, 1, 0, 3));
	// store data straight from the memory stage
	emit(store_word(4, 3, 0));
	emit(rtype_word(32, 1, 2, 0, 4));
	// slt and slti with negative operands
	emit(rtype_word(0, 2, 4, 2, 5));
	emit(itype_word(op_itype, -9, 4, 2, 6));
	emit(rtype_word(0, 1, 4, 7, 7));
	emit(rtype_word(0, 1, 4, 6, 8));
	emit(itype_word(op_itype, 240, 8, 7, 9));
	emit(itype_word(op_itype, -256, 9, 6, 10));
	for (int r = 5; r <= 10; r++) begin
		emit(store_word(4 * (r - 3), r, 0));
	end
	// load-use into an add
	emit(itype_word(op_load, 4, 0, 2, 11));
	emit(rtype_word(0, 1, 11, 0, 12));
	emit(store_word(32, 12, 0));
	// load-use into a taken beq
	emit(itype_word(op_load, 0, 0, 2, 13));
	emit(branch_word(8, 1, 13, 0));
	emit(store_word(36, 2, 0));
	emit(itype_word(op_itype, 2, 0, 0, 14));
	// untaken bne fed from execute
	emit(branch_word(8, 3, 14, 1));
	emit(store_word(40, 14, 0));
	emit(branch_word(8, 1, 14, 0));
	emit(store_word(44, 1, 0));
	emit(branch_word(8, 1, 4, 1));
	emit(store_word(48, 4, 0));
	emit(jal_word(8, 15));
	emit(store_word(52, 3, 0));
	// link value of the jal
	emit(store_word(56, 15, 0));
	emit(itype_word(op_itype, 7, 0, 0, 0));
	emit(store_word(60, 0, 0));
	emit(itype_word(op_load, 56, 0, 2, 16));
	emit(store_word(64, 16, 0));
	emit(jal_word(0, 0));
endtask

//----------------------------------------------------------------------
// one instruction at a time, no pipeline
//----------------------------------------------------------------------
function automatic void ref_run();
	word_t      regs [32];
	word_t      pc;
	word_t      pc_next;
	word_t      ins;
	word_t      a;
	word_t      b;
	word_t      imm;
	word_t      ea;
	word_t      res;
	logic [6:0] opc;
	logic [2:0] f3;
	logic       wr;
	logic       halt;
	int         steps;
	foreach (regs[i]) regs[i] = '0;
	foreach (exp_ram[i]) exp_ram[i] = ram[i];
	pc    = '0;
	halt  = 1'b0;
	steps = 0;
	while (!halt && steps < 1000) begin
		ins     = rom[pc[9:2]];
		opc     = ins[6:0];
		f3      = ins[14:12];
		a       = regs[ins[19:15]];
		b       = regs[ins[24:20]];
		imm     = {{20{ins[31]}}, ins[31:20]};
		ea      = a + imm;
		res     = '0;
		wr      = 1'b0;
		pc_next = pc + 32'd4;
		case (opc)
			op_rtype, op_itype: begin
				if (opc == op_itype) begin
					b = imm;
				end
				case (f3)
					3'b000:  res = (opc == op_rtype && ins[30]) ? a - b : a + b;
					3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					3'b110:  res = a | b;
					default: res = a & b;
				endcase
				wr = 1'b1;
			end
			op_load: begin
				res = exp_ram[ea[7:2]];
				wr  = 1'b1;
			end
			op_store: begin
				ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
				exp_addr.push_back(ea[31:2]);
				exp_data.push_back(b);
				exp_ram[ea[7:2]] = b;
			end
			op_branch: begin
				imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
				if ((a == b) != f3[0]) begin
					pc_next = pc + imm;
				end
			end
			op_jal: begin
				imm     = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
				halt    = (imm == '0);
				res     = pc + 32'd4;
				wr      = 1'b1;
				pc_next = pc + imm;
			end
			default: begin
			end
		endcase
		if (wr && ins[11:7] != 5'd0) begin
			regs[ins[11:7]] = res;
		end
		pc = pc_next;
		steps++;
	end
endfunction

`endif

/* tb/tb_rv_core.sv */
// ROM and RAM stall 0 to 3 cycles per access; the run ends 20 cycles after the last expected store
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core import rv_pkg::*; ();

	logic   clk;
	logic   rst_n;
	waddr_t imem_addr;
	word_t  imem_rdata;
	logic   imem_stall = 1'b0;
	logic   dmem_re;
	logic   dmem_we;
	waddr_t dmem_addr;
	word_t  dmem_wdata;
	word_t  dmem_rdata;
	logic   dmem_stall = 1'b0;

	word_t  rom [256];
	word_t  ram [64];
	word_t  exp_ram [64];
	word_t  rom_word;
	waddr_t exp_addr [$];
	word_t  exp_data [$];
	waddr_t got_addr [$];
	word_t  got_data [$];
	int     prog_len;
	int     i_wait = 0;
	int     d_wait = 0;
	logic   d_busy = 1'b0;
	logic   [63:0] req_snap;
	logic   store_seen = 1'b0;
	int     cycles = 0;
	int     limit;
	int     n_seen = 0;
	int     drain = 0;

	`include "ref_model.svh"

	rv_core_top i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_addr  (imem_addr),
		.imem_rdata (imem_rdata),
		.imem_stall (imem_stall),
		.dmem_re    (dmem_re),
		.dmem_we    (dmem_we),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_rdata (dmem_rdata),
		.dmem_stall (dmem_stall)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_addr(input string name, input waddr_t got, input waddr_t exp);
		if (got !== exp) begin
			fail_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
		end
	endtask

	task automatic check_data(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			fail_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
		end
	endtask

	//----------------------------------------------------------------------
	// memory models
	//----------------------------------------------------------------------
	// beyond the ROM everything reads as nop
	assign rom_word   = (imem_addr[29:8] == '0) ? rom[imem_addr[7:0]] : nop_instr;
	assign imem_rdata = imem_stall ? 32'hdead_beef : rom_word;
	assign dmem_rdata = (dmem_re && !dmem_stall) ? ram[dmem_addr[5:0]] : 32'hbad0_0bad;

	always @(negedge clk) begin
		if (!rst_n) begin
			i_wait     = 0;
			d_wait     = 0;
			d_busy     = 1'b0;
			imem_stall = 1'b0;
			dmem_stall = 1'b0;
			if (dmem_re || dmem_we) begin
				fail_run("data request seen during reset");
			end
		end else begin
			if (i_wait == 0) begin
				i_wait = $urandom_range(3, 0);
			end else begin
				i_wait--;
			end
			imem_stall = (i_wait != 0);

			if (dmem_re && dmem_we) begin
				fail_run("read and write requested in the same cycle");
			end
			if (dmem_re && !store_seen) begin
				fail_run("data read issued before the first store");
			end
			if (dmem_re || dmem_we) begin
				if (!d_busy) begin
					d_wait   = $urandom_range(3, 0);
					d_busy   = 1'b1;
					req_snap = {dmem_re, dmem_we, dmem_addr, dmem_wdata};
				end else begin
					if (req_snap != {dmem_re, dmem_we, dmem_addr, dmem_wdata}) begin
						fail_run("data request changed while the port was stalled");
					end
					if (d_wait > 0) begin
						d_wait--;
					end
				end
				dmem_stall = (d_wait != 0);
				// completes on the coming rising edge
				if (!dmem_stall) begin
					d_busy = 1'b0;
					if (dmem_addr[29:6] != '0) begin
						fail_run("data access outside the RAM");
					end
					if (dmem_we) begin
						ram[dmem_addr[5:0]] = dmem_wdata;
						got_addr.push_back(dmem_addr);
						got_data.push_back(dmem_wdata);
						store_seen = 1'b1;
					end
				end
			end else begin
				d_busy     = 1'b0;
				dmem_stall = 1'b0;
			end
		end
	end

	//----------------------------------------------------------------------
	// stimulus and store compare
	//----------------------------------------------------------------------
	initial begin
		rst_n = 1'b0;
		void'($urandom(24126));
		foreach (rom[i]) rom[i] = nop_instr;
		foreach (ram[i]) ram[i] = (word_t'(i) * 32'h0001_0003) ^ 32'ha5a5_0000;
		build_program();
		ref_run();
		limit = 40 * prog_len + 200;

		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n <= 1'b1;

		while (drain < 20) begin
			@(posedge clk);
			cycles++;
			if (cycles > limit) begin
				fail_run($sformatf("timeout after %0d cycles, %0d of %0d stores seen",
					cycles, n_seen, exp_addr.size()));
			end
			while (got_addr.size() > 0) begin
				if (n_seen >= exp_addr.size()) begin
					fail_run("store seen beyond the expected stream");
				end
				check_addr("dmem_addr", got_addr.pop_front(), exp_addr[n_seen]);
				check_data("dmem_wdata", got_data.pop_front(), exp_data[n_seen]);
				n_seen++;
			end
			if (n_seen == exp_addr.size()) begin
				drain++;
			end
		end

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

/* design/rv_core_top.sv */
// imem_rdata must be valid whenever imem_stall is low; dmem requests stay stable while dmem_stall is high
`timescale 1ns/1ps
`default_nettype none

module rv_core_top import rv_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	output waddr_t imem_addr,
	input  word_t  imem_rdata,
	input  logic   imem_stall,
	output logic   dmem_re,
	output logic   dmem_we,
	output waddr_t dmem_addr,
	output word_t  dmem_wdata,
	input  word_t  dmem_rdata,
	input  logic   dmem_stall
);

	logic     freeze;
	logic     redirect;
	logic     hold;
	word_t    target;
	word_t    instr;
	word_t    pc_plus4;
	reg_idx_t rs1;
	reg_idx_t rs2;
	reg_idx_t ex_rs1;
	reg_idx_t ex_rs2;
	fwd_sel_t fwd_a;
	fwd_sel_t fwd_b;
	fwd_sel_t ex_fwd_a;
	fwd_sel_t ex_fwd_b;
	id_ex_t   id_ex;
	ex_mem_t  ex_mem;

	bypass_ifc byp ();

	fetch_unit u_fetch (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_stall (imem_stall),
		.dmem_stall (dmem_stall),
		.imem_rdata (imem_rdata),
		.imem_addr  (imem_addr),
		.redirect   (redirect),
		.hold       (hold),
		.target     (target),
		.freeze     (freeze),
		.instr      (instr),
		.pc_plus4   (pc_plus4)
	);

	decode_stage u_decode (
		.clk      (clk),
		.rst_n    (rst_n),
		.freeze   (freeze),
		.instr    (instr),
		.pc_plus4 (pc_plus4),
		.fwd_a    (fwd_a),
		.fwd_b    (fwd_b),
		.byp      (byp),
		.redirect (redirect),
		.hold     (hold),
		.target   (target),
		.rs1      (rs1),
		.rs2      (rs2),
		.id_ex    (id_ex)
	);

	forward_unit u_forward (
		.rs1      (rs1),
		.rs2      (rs2),
		.ex_rs1   (ex_rs1),
		.ex_rs2   (ex_rs2),
		.byp      (byp),
		.fwd_a    (fwd_a),
		.fwd_b    (fwd_b),
		.ex_fwd_a (ex_fwd_a),
		.ex_fwd_b (ex_fwd_b)
	);

	execute_stage u_execute (
		.clk      (clk),
		.rst_n    (rst_n),
		.freeze   (freeze),
		.id_ex    (id_ex),
		.ex_fwd_a (ex_fwd_a),
		.ex_fwd_b (ex_fwd_b),
		.ex_rs1   (ex_rs1),
		.ex_rs2   (ex_rs2),
		.byp_src  (byp),
		.byp      (byp),
		.ex_mem   (ex_mem)
	);

	mem_wb_stage u_mem_wb (
		.clk        (clk),
		.rst_n      (rst_n),
		.freeze     (freeze),
		.ex_mem     (ex_mem),
		.dmem_re    (dmem_re),
		.dmem_we    (dmem_we),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_rdata (dmem_rdata),
		.dmem_stall (dmem_stall),
		.byp_mem    (byp),
		.byp_wb     (byp)
	);

endmodule

`default_nettype wire

/* design/mem_wb_stage.sv */
// a data access that completes while fetch stalls is not repeated; its read data is kept until release
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage import rv_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       freeze,
	input  ex_mem_t    ex_mem,
	output logic       dmem_re,
	output logic       dmem_we,
	output waddr_t     dmem_addr,
	output word_t      dmem_wdata,
	input  word_t      dmem_rdata,
	input  logic       dmem_stall,
	bypass_ifc.mem_src byp_mem,
	bypass_ifc.wb_src  byp_wb
);

	logic     acc_done;
	word_t    rdata_hold;
	word_t    load_data;
	word_t    mem_result;
	logic     wb_regwrite;
	logic     wb_is_load;
	reg_idx_t wb_rd;
	word_t    wb_load;
	word_t    wb_result;

	assign dmem_re    = ex_mem.ctrl.memread && !acc_done;
	assign dmem_we    = ex_mem.ctrl.memwrite && !acc_done;
	assign dmem_addr  = ex_mem.alu_res[xlen-1:2];
	assign dmem_wdata = ex_mem.store_data;

	// set once the access is through but the fetch side still freezes us
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			acc_done <= 1'b0;
		end else if (!freeze) begin
			acc_done <= 1'b0;
		end else if ((dmem_re || dmem_we) && !dmem_stall) begin
			acc_done <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (dmem_re && !dmem_stall) begin
			rdata_hold <= dmem_rdata;
		end
	end

	assign load_data  = acc_done ? rdata_hold : dmem_rdata;
	assign mem_result = ex_mem.ctrl.is_jal ? ex_mem.pc_plus4 : ex_mem.alu_res;

	assign byp_mem.mem_rd       = ex_mem.rd;
	assign byp_mem.mem_regwrite = ex_mem.ctrl.regwrite;
	assign byp_mem.mem_memread  = ex_mem.ctrl.memread;
	assign byp_mem.mem_value    = mem_result;

	//----------------------------------------------------------------------
	// MEM/WB register
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_regwrite <= 1'b0;
			wb_is_load  <= 1'b0;
		end else if (!freeze) begin
			wb_regwrite <= ex_mem.ctrl.regwrite;
			wb_is_load  <= ex_mem.ctrl.memread;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			wb_rd     <= ex_mem.rd;
			wb_load   <= load_data;
			wb_result <= mem_result;
		end
	end

	assign byp_wb.wb_rd       = wb_rd;
	assign byp_wb.wb_regwrite = wb_regwrite;
	assign byp_wb.wb_value    = wb_is_load ? wb_load : wb_result;

endmodule

`default_nettype wire

/* design/execute_stage.sv */
// alu covers add, sub, and, or and signed slt only; jal passes through with its link in pc_plus4
`timescale 1ns/1ps
`default_nettype none

module execute_stage import rv_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      freeze,
	input  id_ex_t    id_ex,
	input  fwd_sel_t  ex_fwd_a,
	input  fwd_sel_t  ex_fwd_b,
	output reg_idx_t  ex_rs1,
	output reg_idx_t  ex_rs2,
	bypass_ifc.ex_src byp_src,
	bypass_ifc.sink   byp,
	output ex_mem_t   ex_mem
);

	word_t op_a;
	word_t rs2_fwd;
	word_t op_b;
	word_t alu_res;

	function automatic word_t operand(input fwd_sel_t sel, input word_t reg_val);
		word_t val;
		case (sel)
			fwd_mem: val = byp.mem_value;
			fwd_wb:  val = byp.wb_value;
			default: val = reg_val;
		endcase
		return val;
	endfunction

	assign ex_rs1 = id_ex.rs1;
	assign ex_rs2 = id_ex.rs2;

	always_comb begin
		op_a    = operand(ex_fwd_a, id_ex.rs1_val);
		rs2_fwd = operand(ex_fwd_b, id_ex.rs2_val);
		op_b    = id_ex.ctrl.alusrc ? id_ex.imm : rs2_fwd;
	end

	always_comb begin
		case (id_ex.ctrl.alu_op)
			alu_sub: alu_res = op_a - op_b;
			alu_and: alu_res = op_a & op_b;
			alu_or:  alu_res = op_a | op_b;
			alu_slt: alu_res = word_t'($signed(op_a) < $signed(op_b));
			default: alu_res = op_a + op_b;
		endcase
	end

	assign byp_src.ex_rd       = id_ex.rd;
	assign byp_src.ex_regwrite = id_ex.ctrl.regwrite;
	assign byp_src.ex_memread  = id_ex.ctrl.memread;
	assign byp_src.ex_value    = alu_res;

	//----------------------------------------------------------------------
	// EX/MEM register
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_mem <= '0;
		end else if (!freeze) begin
			ex_mem.ctrl       <= id_ex.ctrl;
			ex_mem.rd         <= id_ex.rd;
			ex_mem.alu_res    <= alu_res;
			ex_mem.store_data <= rs2_fwd;
			ex_mem.pc_plus4   <= id_ex.pc_plus4;
		end
	end

endmodule

`default_nettype wire

/* design/decode_stage.sv */
// branches and jal resolve here; rs2 is compared for every format, so a few holds are spurious
`timescale 1ns/1ps
`default_nettype none

module decode_stage import rv_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     freeze,
	input  word_t    instr,
	input  word_t    pc_plus4,
	input  fwd_sel_t fwd_a,
	input  fwd_sel_t fwd_b,
	bypass_ifc.sink  byp,
	output logic     redirect,
	output logic     hold,
	output word_t    target,
	output reg_idx_t rs1,
	output reg_idx_t rs2,
	output id_ex_t   id_ex
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	reg_idx_t   rd;
	ctrl_t      ctrl;
	logic       is_branch;
	word_t      imm;
	word_t      rda;
	word_t      rdb;
	word_t      br_a;
	word_t      br_b;
	logic       taken;
	logic       load_use;
	logic       branch_wait;

	function automatic alu_op_t alu_func(input logic [2:0] f3, input logic alt);
		alu_op_t op;
		case (f3)
			3'b000:  op = alt ? alu_sub : alu_add;
			3'b010:  op = alu_slt;
			3'b110:  op = alu_or;
			3'b111:  op = alu_and;
			default: op = alu_add;
		endcase
		return op;
	endfunction

	assign opcode = instr[6:0];
	assign rd     = instr[11:7];
	assign funct3 = instr[14:12];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];

	reg_file u_reg_file (
		.clk   (clk),
		.rst_n (rst_n),
		.we    (byp.wb_regwrite),
		.ra    (rs1),
		.rb    (rs2),
		.wa    (byp.wb_rd),
		.wd    (byp.wb_value),
		.rda   (rda),
		.rdb   (rdb)
	);

	//----------------------------------------------------------------------
	// control and immediate
	//----------------------------------------------------------------------
	always_comb begin
		ctrl      = '0;
		is_branch = 1'b0;
		imm       = '0;
		case (opcode)
			op_rtype: begin
				ctrl.regwrite = 1'b1;
				ctrl.alu_op   = alu_func(funct3, instr[30]);
			end
			op_itype: begin
				ctrl.regwrite = 1'b1;
				ctrl.alusrc   = 1'b1;
				ctrl.alu_op   = alu_func(funct3, 1'b0);
				imm           = {{20{instr[31]}}, instr[31:20]};
			end
			op_load: begin
				ctrl.regwrite = 1'b1;
				ctrl.memread  = 1'b1;
				ctrl.alusrc   = 1'b1;
				imm           = {{20{instr[31]}}, instr[31:20]};
			end
			op_store: begin
				ctrl.memwrite = 1'b1;
				ctrl.alusrc   = 1'b1;
				imm           = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			end
			op_branch: begin
				is_branch = 1'b1;
				imm       = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			end
			op_jal: begin
				ctrl.regwrite = 1'b1;
				ctrl.is_jal   = 1'b1;
				imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			end
			default: begin
			end
		endcase
	end

	// branch compare sees the freshest copy of each operand
	always_comb begin
		case (fwd_a)
			fwd_ex:  br_a = byp.ex_value;
			fwd_mem: br_a = byp.mem_value;
			fwd_wb:  br_a = byp.wb_value;
			default: br_a = rda;
		endcase
		case (fwd_b)
			fwd_ex:  br_b = byp.ex_value;
			fwd_mem: br_b = byp.mem_value;
			fwd_wb:  br_b = byp.wb_value;
			default: br_b = rdb;
		endcase
	end

	// funct3[0] set means bne
	assign taken  = (is_branch && ((br_a == br_b) != funct3[0])) || ctrl.is_jal;
	assign target = pc_plus4 - word_t'(4) + imm;

	//----------------------------------------------------------------------
	// hazards
	//----------------------------------------------------------------------
	assign load_use = byp.ex_memread && (byp.ex_rd != '0) &&
		((byp.ex_rd == rs1) || (byp.ex_rd == rs2));
	// load data only shows up in writeback, too late for the compare
	assign branch_wait = is_branch && byp.mem_memread && (byp.mem_rd != '0) &&
		((byp.mem_rd == rs1) || (byp.mem_rd == rs2));
	assign hold     = load_use || branch_wait;
	assign redirect = taken && !hold;

	//----------------------------------------------------------------------
	// ID/EX register
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			id_ex <= '0;
		end else if (!freeze) begin
			if (hold) begin
				id_ex <= '0;
			end else begin
				id_ex.ctrl     <= ctrl;
				id_ex.rs1      <= rs1;
				id_ex.rs2      <= rs2;
				id_ex.rd       <= rd;
				id_ex.rs1_val  <= rda;
				id_ex.rs2_val  <= rdb;
				id_ex.imm      <= imm;
				id_ex.pc_plus4 <= pc_plus4;
			end
		end
	end

endmodule

`default_nettype wire

/* design/fetch_unit.sv */
// fetch restarts at address 0 after reset; a stall on either memory port freezes the whole core
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import rv_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   imem_stall,
	input  logic   dmem_stall,
	input  word_t  imem_rdata,
	output waddr_t imem_addr,
	input  logic   redirect,
	input  logic   hold,
	input  word_t  target,
	output logic   freeze,
	output word_t  instr,
	output word_t  pc_plus4
);

	word_t pc;
	word_t pc_next4;

	assign freeze    = imem_stall | dmem_stall;
	assign imem_addr = pc[xlen-1:2];
	assign pc_next4  = pc + word_t'(4);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (!(freeze || hold)) begin
			pc <= redirect ? target : pc_next4;
		end
	end

	//----------------------------------------------------------------------
	// IF/ID register
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			instr    <= nop_instr;
			pc_plus4 <= '0;
		end else if (!(freeze || hold)) begin
			// squash the word fetched behind a taken branch or jal
			instr    <= redirect ? nop_instr : imem_rdata;
			pc_plus4 <= pc_next4;
		end
	end

endmodule

`default_nettype wire

/* design/forward_unit.sv */
// purely combinational; execute never forwards from itself, loads in flight are held off by decode
`timescale 1ns/1ps
`default_nettype none

module forward_unit import rv_pkg::*; (
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	input  reg_idx_t ex_rs1,
	input  reg_idx_t ex_rs2,
	bypass_ifc.sink  byp,
	output fwd_sel_t fwd_a,
	output fwd_sel_t fwd_b,
	output fwd_sel_t ex_fwd_a,
	output fwd_sel_t ex_fwd_b
);

	// youngest enabled writer wins, x0 never forwards
	function automatic fwd_sel_t pick(input reg_idx_t src, input logic from_ex);
		fwd_sel_t sel;
		sel = fwd_none;
		if (src != '0) begin
			if (from_ex && byp.ex_regwrite && (byp.ex_rd == src)) begin
				sel = fwd_ex;
			end else if (byp.mem_regwrite && (byp.mem_rd == src)) begin
				sel = fwd_mem;
			end else if (byp.wb_regwrite && (byp.wb_rd == src)) begin
				sel = fwd_wb;
			end
		end
		return sel;
	endfunction

	always_comb begin
		fwd_a    = pick(rs1, 1'b1);
		fwd_b    = pick(rs2, 1'b1);
		ex_fwd_a = pick(ex_rs1, 1'b0);
		ex_fwd_b = pick(ex_rs2, 1'b0);
	end

endmodule

`default_nettype wire

/* design/reg_file.sv */
// two read ports and one write port; a write in the current cycle shows on the read ports
`timescale 1ns/1ps
`default_nettype none

module reg_file import rv_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     we,
	input  reg_idx_t ra,
	input  reg_idx_t rb,
	input  reg_idx_t wa,
	input  word_t    wd,
	output word_t    rda,
	output word_t    rdb
);

	word_t regs [32];

	function automatic word_t read_port(input reg_idx_t idx);
		word_t val;
		if (idx == '0) begin
			val = '0;
		end else if (we && (wa == idx)) begin
			val = wd;
		end else begin
			val = regs[idx];
		end
		return val;
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wa != '0)) begin
			regs[wa] <= wd;
		end
	end

	always_comb begin
		rda = read_port(ra);
		rdb = read_port(rb);
	end

endmodule

`default_nettype wire

/* design/bypass_ifc.sv */
// one driver per stage group; ex_value is the raw ALU result, so loads in execute are not valid
`timescale 1ns/1ps
`default_nettype none

interface bypass_ifc import rv_pkg::*; ();

	// execute stage writer
	reg_idx_t ex_rd;
	logic     ex_regwrite;
	logic     ex_memread;
	word_t    ex_value;

	// memory stage writer
	reg_idx_t mem_rd;
	logic     mem_regwrite;
	logic     mem_memread;
	word_t    mem_value;

	// writeback
	reg_idx_t wb_rd;
	logic     wb_regwrite;
	word_t    wb_value;

	modport ex_src (output ex_rd, ex_regwrite, ex_memread, ex_value);
	modport mem_src (output mem_rd, mem_regwrite, mem_memread, mem_value);
	modport wb_src (output wb_rd, wb_regwrite, wb_value);
	modport sink (
		input ex_rd, ex_regwrite, ex_memread, ex_value,
		input mem_rd, mem_regwrite, mem_memread, mem_value,
		input wb_rd, wb_regwrite, wb_value
	);

endinterface

`default_nettype wire

/* design/rv_pkg.sv */
// word accesses only; opcodes cover the rv32i subset this core executes, nothing else decodes
`default_nettype none

package rv_pkg;

	localparam int xlen = 32;

	typedef logic [xlen-1:0] word_t;
	typedef logic [xlen-3:0] waddr_t;
	typedef logic [4:0]      reg_idx_t;

	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or  = 3'd3,
		alu_slt = 3'd4
	} alu_op_t;

	// where an operand comes from when it is still in flight
	typedef enum logic [1:0] {
		fwd_none = 2'd0,
		fwd_ex   = 2'd1,
		fwd_mem  = 2'd2,
		fwd_wb   = 2'd3
	} fwd_sel_t;

	localparam logic [6:0] op_rtype  = 7'b0110011;
	localparam logic [6:0] op_itype  = 7'b0010011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_jal    = 7'b1101111;

	// addi x0,x0,0
	localparam word_t nop_instr = 32'h0000_0013;

	//----------------------------------------------------------------------
	// pipeline register layouts
	//----------------------------------------------------------------------
	typedef struct packed {
		logic    regwrite;
		logic    memread;
		logic    memwrite;
		logic    alusrc;
		logic    is_jal;
		alu_op_t alu_op;
	} ctrl_t;

	typedef struct packed {
		ctrl_t    ctrl;
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
		word_t    rs1_val;
		word_t    rs2_val;
		word_t    imm;
		word_t    pc_plus4;
	} id_ex_t;

	typedef struct packed {
		ctrl_t    ctrl;
		reg_idx_t rd;
		word_t    alu_res;
		word_t    store_data;
		word_t    pc_plus4;
	} ex_mem_t;

endpackage

`default_nettype wire
